// ==== verilog.f ====
+incdir+design
design/nes_mem_pkg.sv
design/nes_pad_pkg.sv
design/rom_load_sequencer.sv
design/rv_word_bridge.sv
design/joypad_serializer.sv
design/nes_glue_top.sv
sim/tb_nes_glue.sv

// ==== Makefile ====
# NES glue simulation with Verilator

TB_TOP  = tb_nes_glue
RTL_TOP = nes_glue_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TB_TOP) \
		-Mdir obj_dir -o $(TB_TOP)

run: build
	@out="$$(./obj_dir/$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '\*\*\* PASSED \*\*\*'

lint:
	verilator --lint-only -Wall -f verilog.f --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir

// ==== sim/nes_glue_golden.txt ====
# records, all operands hex
# LOADSTART | LOADEND | LWRITE addr byte | CPUREAD addr exp_oe exp_mem_addr
# DONE flags exp_ext_audio | RVWR addr wdata wstrb ack_delay | RVRD addr exp_rdata ack_delay
# PADLOAD btns1 btns2 | PADCLK port_mask fall_count exp_pad_data
LOADSTART
LWRITE 012345 a5
LWRITE 3ffffe 5c
CPUREAD 001234 0 3ffffe
DONE 0000000000000013 1
DONE 00000000abcd0018 1
DONE 000000000000001a 1
DONE ffff00000000001b 0
DONE 0000000000001304 0
LOADEND
CPUREAD 002000 1 002000
RVRD 000104 5a835a82 2
RVWR 000100 11223344 f 2
RVRD 000100 11223344 3
RVWR 000100 aaaa5566 3 4
RVRD 000100 11225566 2
RVWR 000100 77889999 c 3
RVRD 000100 77885566 4
RVWR 000104 deadbeef 5 2
RVRD 000104 5aad5aef 3
PADLOAD 35 ca
PADCLK 1 8 1
PADCLK 2 3 3
PADCLK 3 5 3
PADLOAD 5a 0f
PADCLK 3 4 1
PADCLK 1 1 0

// ==== sim/tb_nes_glue.sv ====
/*
 * NES glue testbench
 * plays golden records against the glue top level, models the
 * half-word toggle memory and checks every response
 */
`timescale 1ns/10ps
`include "nes_glue_config.svh"

module tb_nes_glue;
    import nes_mem_pkg::*;
    import nes_pad_pkg::*;

    localparam int CYCLES_PER_RECORD = 300;
    localparam int READY_LIMIT       = 64;

    logic          clk;
    logic          sys_resetn;
    logic          i_loading;
    logic          i_loader_write;
    mem_addr_t     i_loader_addr;
    mem_byte_t     i_loader_data;
    logic          i_loader_done;
    mapper_flags_t i_loader_flags;
    mem_addr_t     i_cpu_addr;
    logic          i_cpu_read;
    logic          i_cpu_write;
    mem_byte_t     i_cpu_dout;
    mem_addr_t     o_mem_addr;
    mem_byte_t     o_mem_din;
    logic          o_mem_we;
    logic          o_mem_oe;
    logic          o_loader_reset;
    logic          o_reset_nes;
    logic          o_clkref;
    mapper_flags_t o_mapper_flags;
    logic          o_ext_audio;
    logic          i_rv_valid;
    rv_addr_t      i_rv_addr;
    rv_word_t      i_rv_wdata;
    rv_strb_t      i_rv_wstrb;
    logic          o_rv_ready;
    rv_word_t      o_rv_rdata;
    logic          i_rv_req_ack;
    rv_half_t      i_rv_dout;
    logic          o_rv_req;
    logic          o_rv_word;
    rv_ds_t        o_rv_ds;
    logic          o_rv_we;
    rv_half_t      o_rv_din;
    rv_addr_t      o_rv_addr;
    logic          i_pad_strobe;
    pad_clock_t    i_pad_clock;
    pad_buttons_t  i_btns1;
    pad_buttons_t  i_btns2;
    pad_data_t     o_pad_data;

    // half-word memory behind the toggle port
    rv_half_t      mem_model [256];
    logic [7:0]    mem_idx;
    logic          mem_busy;
    int            mem_cnt;
    int            mem_delay;

    // loaded buttons and falling clocks seen per port
    pad_buttons_t  pad_btns [`PAD_PORTS];
    int            pad_shifts [`PAD_PORTS];

    string         records [$];
    int            num_records;
    int            check_count;
    int            error_count;

    nes_glue_top u_nes_glue_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // word address plus the half select
    assign mem_idx = {o_rv_addr[8:2], o_rv_word};

    ////////////////////////////////////////////////////////////////////////////
    // toggle-port memory model

    initial begin
        i_rv_req_ack = 1'b0;
        i_rv_dout    = '0;
        mem_busy     = 1'b0;
        mem_cnt      = 0;
        forever begin
            @(negedge clk);
            if (!sys_resetn) begin
                mem_busy = 1'b0;
                for (int i = 0; i < 256; i++) begin
                    mem_model[i] = 16'h5A00 ^ 16'(i);
                end
            end else if (!mem_busy) begin
                // new request pending
                if (o_rv_req != i_rv_req_ack) begin
                    mem_busy = 1'b1;
                    mem_cnt  = mem_delay - 2;
                end
            end else if (mem_cnt > 0) begin
                mem_cnt = mem_cnt - 1;
            end else begin
                mem_busy = 1'b0;
                if (o_rv_we) begin
                    if (o_rv_ds[0]) begin
                        mem_model[mem_idx][7:0] = o_rv_din[7:0];
                    end
                    if (o_rv_ds[1]) begin
                        mem_model[mem_idx][15:8] = o_rv_din[15:8];
                    end
                end else begin
                    // held until the next read answer
                    i_rv_dout <= mem_model[mem_idx];
                end
                i_rv_req_ack <= o_rv_req;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s at %0t: expected %h, got %h", name, $time, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input mem_byte_t exp, input mem_byte_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s at %0t: expected %h, got %h", name, $time, exp, act);
        end
    endtask

    task automatic check_word(input string name, input rv_word_t exp, input rv_word_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s at %0t: expected %h, got %h", name, $time, exp, act);
        end
    endtask

    task automatic check_flags(input string name, input mapper_flags_t exp,
                               input mapper_flags_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s at %0t: expected %h, got %h", name, $time, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH %s at %0t: expected %h, got %h", name, $time, exp, act);
        end
    endtask

    // button at the shift position or a one once every button is out
    function automatic logic expected_pad_bit(input int p);
        if (pad_shifts[p] >= `PAD_BITS) begin
            return 1'b1;
        end
        return pad_btns[p][pad_shifts[p]];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // record actions

    task automatic start_load();
        @(negedge clk);
        i_loading = 1'b1;
        @(negedge clk);
        check_bit("o_loader_reset", 1'b1, o_loader_reset);
        check_bit("o_reset_nes", 1'b1, o_reset_nes);
        @(negedge clk);
        check_bit("o_loader_reset", 1'b0, o_loader_reset);
    endtask

    task automatic end_load();
        @(negedge clk);
        i_loading = 1'b0;
        @(negedge clk);
        check_bit("o_reset_nes", 1'b0, o_reset_nes);
        check_bit("o_clkref", 1'b1, o_clkref);
        // phase reference free runs again
        @(negedge clk);
        check_bit("o_clkref", 1'b0, o_clkref);
        @(negedge clk);
        check_bit("o_clkref", 1'b1, o_clkref);
    endtask

    task automatic loader_write(input mem_addr_t addr, input mem_byte_t data);
        @(negedge clk);
        i_loader_write = 1'b1;
        i_loader_addr  = addr;
        i_loader_data  = data;
        // we held for two cycles
        repeat (2) begin
            @(negedge clk);
            i_loader_write = 1'b0;
            check_bit("o_mem_we", 1'b1, o_mem_we);
            check_addr("o_mem_addr", addr, o_mem_addr);
            check_byte("o_mem_din", data, o_mem_din);
        end
        @(negedge clk);
        check_bit("o_mem_we", 1'b0, o_mem_we);
    endtask

    task automatic cpu_read(input mem_addr_t addr, input logic exp_oe, input mem_addr_t exp_addr);
        @(negedge clk);
        i_cpu_read = 1'b1;
        i_cpu_addr = addr;
        @(negedge clk);
        check_bit("o_mem_oe", exp_oe, o_mem_oe);
        check_addr("o_mem_addr", exp_addr, o_mem_addr);
        i_cpu_read = 1'b0;
    endtask

    task automatic loader_done(input mapper_flags_t flags, input logic exp_ext);
        @(negedge clk);
        i_loader_done  = 1'b1;
        i_loader_flags = flags;
        @(negedge clk);
        i_loader_done = 1'b0;
        check_flags("o_mapper_flags", flags, o_mapper_flags);
        check_bit("o_ext_audio", exp_ext, o_ext_audio);
    endtask

    // one core access where data is the read expectation for reads
    task automatic rv_access(input logic is_read, input rv_addr_t addr, input rv_word_t data,
                             input rv_strb_t strb, input int delay);
        int waited;
        @(negedge clk);
        mem_delay  = delay;
        i_rv_valid = 1'b1;
        i_rv_addr  = addr;
        i_rv_wdata = is_read ? '0 : data;
        i_rv_wstrb = is_read ? '0 : strb;
        @(negedge clk);
        waited = 1;
        while (!o_rv_ready && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_rv_ready) begin
            error_count++;
            $display("no o_rv_ready within %0d cycles for the access at %h", READY_LIMIT, addr);
        end else if (is_read) begin
            check_word("o_rv_rdata", data, o_rv_rdata);
        end
        i_rv_valid = 1'b0;
        i_rv_wstrb = '0;
    endtask

    task automatic pad_load(input pad_buttons_t btns1, input pad_buttons_t btns2);
        @(negedge clk);
        i_pad_strobe  = 1'b1;
        i_btns1       = btns1;
        i_btns2       = btns2;
        pad_btns[0]   = btns1;
        pad_btns[1]   = btns2;
        pad_shifts[0] = 0;
        pad_shifts[1] = 0;
        @(negedge clk);
        i_pad_strobe = 1'b0;
        check_bit("o_pad_data[0]", expected_pad_bit(0), o_pad_data[0]);
        check_bit("o_pad_data[1]", expected_pad_bit(1), o_pad_data[1]);
    endtask

    // falling clocks on the masked ports followed by the golden final bits
    task automatic pad_clock_falls(input pad_clock_t mask, input int count, input pad_data_t exp);
        repeat (count) begin
            @(negedge clk);
            i_pad_clock = ~mask;
            @(negedge clk);
            i_pad_clock = '1;
            for (int p = 0; p < `PAD_PORTS; p++) begin
                if (mask[p]) begin
                    pad_shifts[p]++;
                end
            end
            check_bit("o_pad_data[0]", expected_pad_bit(0), o_pad_data[0]);
            check_bit("o_pad_data[1]", expected_pad_bit(1), o_pad_data[1]);
        end
        check_bit("o_pad_data[0]", exp[0], o_pad_data[0]);
        check_bit("o_pad_data[1]", exp[1], o_pad_data[1]);
    endtask

    task automatic play_record(input string line);
        string       op;
        logic [63:0] f1;
        logic [63:0] f2;
        logic [63:0] f3;
        logic [63:0] f4;
        int          n;
        f1 = '0;
        f2 = '0;
        f3 = '0;
        f4 = '0;
        n  = $sscanf(line, "%s %h %h %h %h", op, f1, f2, f3, f4);
        if (op == "LOADSTART") begin
            start_load();
        end else if (op == "LOADEND") begin
            end_load();
        end else if (op == "LWRITE") begin
            loader_write(mem_addr_t'(f1), mem_byte_t'(f2));
        end else if (op == "CPUREAD") begin
            cpu_read(mem_addr_t'(f1), logic'(f2), mem_addr_t'(f3));
        end else if (op == "DONE") begin
            loader_done(mapper_flags_t'(f1), logic'(f2));
        end else if (op == "RVWR") begin
            rv_access(1'b0, rv_addr_t'(f1), rv_word_t'(f2), rv_strb_t'(f3), int'(f4));
        end else if (op == "RVRD") begin
            rv_access(1'b1, rv_addr_t'(f1), rv_word_t'(f2), '0, int'(f3));
        end else if (op == "PADLOAD") begin
            pad_load(pad_buttons_t'(f1), pad_buttons_t'(f2));
        end else if (op == "PADCLK") begin
            pad_clock_falls(pad_clock_t'(f1), int'(f2), pad_data_t'(f3));
        end else begin
            error_count++;
            $display("unknown golden record (%0d fields): %s", n, line);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int    fd;
        string line;
        sys_resetn     = 1'b0;
        i_loading      = 1'b0;
        i_loader_write = 1'b0;
        i_loader_addr  = '0;
        i_loader_data  = '0;
        i_loader_done  = 1'b0;
        i_loader_flags = '0;
        i_cpu_addr     = '0;
        i_cpu_read     = 1'b0;
        i_cpu_write    = 1'b0;
        i_cpu_dout     = '0;
        i_rv_valid     = 1'b0;
        i_rv_addr      = '0;
        i_rv_wdata     = '0;
        i_rv_wstrb     = '0;
        // serial clocks idle high
        i_pad_strobe   = 1'b0;
        i_pad_clock    = '1;
        i_btns1        = '0;
        i_btns2        = '0;
        mem_delay      = 2;
        check_count    = 0;
        error_count    = 0;

        fd = $fopen("sim/nes_glue_golden.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("cannot open the golden record file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    records.push_back(line);
                end
            end
            $fclose(fd);
        end
        num_records = records.size();

        repeat (2) @(posedge clk);
        @(negedge clk);
        sys_resetn = 1'b1;
        @(negedge clk);
        check_bit("o_reset_nes", 1'b1, o_reset_nes);
        check_bit("o_loader_reset", 1'b0, o_loader_reset);
        check_bit("o_mem_we", 1'b0, o_mem_we);
        check_bit("o_rv_ready", 1'b0, o_rv_ready);

        foreach (records[r]) begin
            play_record(records[r]);
        end

        repeat (2) @(negedge clk);
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // run length scales with the record count
    initial begin
        wait (num_records != 0);
        repeat (num_records * CYCLES_PER_RECORD) @(posedge clk);
        $display("timeout after %0d cycles, run stopped", num_records * CYCLES_PER_RECORD);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== design/nes_glue_top.sv ====
/*
 * NES glue top level
 * ROM-load sequencer, soft-core word bridge and joypad serializer side by side
 */
`timescale 1ns/10ps

module nes_glue_top (
    input  logic                       clk,
    input  logic                       sys_resetn,
    // loader and console memory
    input  logic                       i_loading,
    input  logic                       i_loader_write,
    input  nes_mem_pkg::mem_addr_t     i_loader_addr,
    input  nes_mem_pkg::mem_byte_t     i_loader_data,
    input  logic                       i_loader_done,
    input  nes_mem_pkg::mapper_flags_t i_loader_flags,
    input  nes_mem_pkg::mem_addr_t     i_cpu_addr,
    input  logic                       i_cpu_read,
    input  logic                       i_cpu_write,
    input  nes_mem_pkg::mem_byte_t     i_cpu_dout,
    output nes_mem_pkg::mem_addr_t     o_mem_addr,
    output nes_mem_pkg::mem_byte_t     o_mem_din,
    output logic                       o_mem_we,
    output logic                       o_mem_oe,
    output logic                       o_loader_reset,
    output logic                       o_reset_nes,
    output logic                       o_clkref,
    output nes_mem_pkg::mapper_flags_t o_mapper_flags,
    output logic                       o_ext_audio,
    // soft-core bus
    input  logic                       i_rv_valid,
    input  nes_mem_pkg::rv_addr_t      i_rv_addr,
    input  nes_mem_pkg::rv_word_t      i_rv_wdata,
    input  nes_mem_pkg::rv_strb_t      i_rv_wstrb,
    output logic                       o_rv_ready,
    output nes_mem_pkg::rv_word_t      o_rv_rdata,
    // half-word toggle port
    input  logic                       i_rv_req_ack,
    input  nes_mem_pkg::rv_half_t      i_rv_dout,
    output logic                       o_rv_req,
    output logic                       o_rv_word,
    output nes_mem_pkg::rv_ds_t        o_rv_ds,
    output logic                       o_rv_we,
    output nes_mem_pkg::rv_half_t      o_rv_din,
    output nes_mem_pkg::rv_addr_t      o_rv_addr,
    // joypads
    input  logic                       i_pad_strobe,
    input  nes_pad_pkg::pad_clock_t    i_pad_clock,
    input  nes_pad_pkg::pad_buttons_t  i_btns1,
    input  nes_pad_pkg::pad_buttons_t  i_btns2,
    output nes_pad_pkg::pad_data_t     o_pad_data
);

    ////////////////////////////////////////////////////////////////////////////
    // memory path

    rom_load_sequencer u_load_seq (
        .clk            (clk),
        .sys_resetn     (sys_resetn),
        .i_loading      (i_loading),
        .i_loader_write (i_loader_write),
        .i_loader_addr  (i_loader_addr),
        .i_loader_data  (i_loader_data),
        .i_loader_done  (i_loader_done),
        .i_loader_flags (i_loader_flags),
        .i_cpu_addr     (i_cpu_addr),
        .i_cpu_read     (i_cpu_read),
        .i_cpu_write    (i_cpu_write),
        .i_cpu_dout     (i_cpu_dout),
        .o_mem_addr     (o_mem_addr),
        .o_mem_din      (o_mem_din),
        .o_mem_we       (o_mem_we),
        .o_mem_oe       (o_mem_oe),
        .o_loader_reset (o_loader_reset),
        .o_reset_nes    (o_reset_nes),
        .o_clkref       (o_clkref),
        .o_mapper_flags (o_mapper_flags),
        .o_ext_audio    (o_ext_audio)
    );

    // soft-core accesses
    rv_word_bridge u_rv_bridge (
        .clk          (clk),
        .sys_resetn   (sys_resetn),
        .i_rv_valid   (i_rv_valid),
        .i_rv_addr    (i_rv_addr),
        .i_rv_wdata   (i_rv_wdata),
        .i_rv_wstrb   (i_rv_wstrb),
        .i_rv_req_ack (i_rv_req_ack),
        .i_rv_dout    (i_rv_dout),
        .o_rv_ready   (o_rv_ready),
        .o_rv_rdata   (o_rv_rdata),
        .o_rv_req     (o_rv_req),
        .o_rv_word    (o_rv_word),
        .o_rv_ds      (o_rv_ds),
        .o_rv_we      (o_rv_we),
        .o_rv_din     (o_rv_din),
        .o_rv_addr    (o_rv_addr)
    );

    ////////////////////////////////////////////////////////////////////////////
    // controllers

    joypad_serializer u_joypad (
        .clk          (clk),
        .sys_resetn   (sys_resetn),
        .i_pad_strobe (i_pad_strobe),
        .i_pad_clock  (i_pad_clock),
        .i_btns1      (i_btns1),
        .i_btns2      (i_btns2),
        .o_pad_data   (o_pad_data)
    );

endmodule

// ==== design/joypad_serializer.sv ====
/*
 * Joypad serializer
 * parallel-load shift register per port, shifted on the falling serial clock
 */
`timescale 1ns/10ps
`include "nes_glue_config.svh"

module joypad_serializer (
    input  logic                      clk,
    input  logic                      sys_resetn,
    input  logic                      i_pad_strobe,
    input  nes_pad_pkg::pad_clock_t   i_pad_clock,
    input  nes_pad_pkg::pad_buttons_t i_btns1,
    input  nes_pad_pkg::pad_buttons_t i_btns2,
    output nes_pad_pkg::pad_data_t    o_pad_data
);
    import nes_pad_pkg::*;

    pad_buttons_t btns_in [`PAD_PORTS];
    pad_buttons_t shift_q [`PAD_PORTS];
    pad_clock_t   clk_prev;
    pad_clock_t   clk_fall;

    assign btns_in[0] = i_btns1;
    assign btns_in[1] = i_btns2;

    // high to low since the last sample
    assign clk_fall = clk_prev & ~i_pad_clock;

    // previous clock level for edge detect
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            clk_prev <= '0;
        end else begin
            clk_prev <= i_pad_clock;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // shift registers

    always_ff @(posedge clk) begin
        for (int p = 0; p < `PAD_PORTS; p++) begin
            if (i_pad_strobe) begin
                // strobe high keeps reloading the buttons
                shift_q[p] <= btns_in[p];
            end else if (clk_fall[p]) begin
                // empty register reads back all ones
                shift_q[p] <= {1'b1, shift_q[p][`PAD_BITS-1:1]};
            end
        end
    end

    // A first, then B, Select, Start and the pad
    always_comb begin
        for (int p = 0; p < `PAD_PORTS; p++) begin
            o_pad_data[p] = shift_q[p][0];
        end
    end

endmodule

// ==== design/rv_word_bridge.sv ====
/*
 * Soft-core word bridge
 * splits a 32-bit core access into one or two 16-bit accesses
 * on a toggle-handshake memory port
 */
`timescale 1ns/10ps

module rv_word_bridge (
    input  logic                  clk,
    input  logic                  sys_resetn,
    input  logic                  i_rv_valid,
    input  nes_mem_pkg::rv_addr_t i_rv_addr,
    input  nes_mem_pkg::rv_word_t i_rv_wdata,
    input  nes_mem_pkg::rv_strb_t i_rv_wstrb,
    input  logic                  i_rv_req_ack,
    input  nes_mem_pkg::rv_half_t i_rv_dout,
    output logic                  o_rv_ready,
    output nes_mem_pkg::rv_word_t o_rv_rdata,
    output logic                  o_rv_req,
    output logic                  o_rv_word,
    output nes_mem_pkg::rv_ds_t   o_rv_ds,
    output logic                  o_rv_we,
    output nes_mem_pkg::rv_half_t o_rv_din,
    output nes_mem_pkg::rv_addr_t o_rv_addr
);
    import nes_mem_pkg::*;

    typedef enum logic [2:0] {
        RV_IDLE_REQ0  = 3'd0,
        RV_WAIT0_REQ1 = 3'd1,
        RV_DATA0      = 3'd2,
        RV_WAIT1      = 3'd3,
        RV_DATA1      = 3'd4
    } rv_state_t;

    rv_state_t state;
    logic      valid_r;
    logic      req_pend;
    logic      req_now;
    logic      issue;
    logic      is_write;
    logic      acked;
    rv_half_t  rdata_lo;

    // new request on the rising edge of valid
    assign req_now  = i_rv_valid & ~valid_r;
    assign issue    = (state == RV_IDLE_REQ0) && (req_now || req_pend);
    assign is_write = |i_rv_wstrb;
    // toggle port done when ack catches up
    assign acked    = (o_rv_req == i_rv_req_ack);

    // core holds wdata, pick the half being accessed
    assign o_rv_din = o_rv_word ? i_rv_wdata[31:16] : i_rv_wdata[15:0];

    ////////////////////////////////////////////////////////////////////////////
    // access sequencing

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state      <= RV_IDLE_REQ0;
            valid_r    <= 1'b0;
            req_pend   <= 1'b0;
            o_rv_ready <= 1'b0;
            o_rv_req   <= 1'b0;
            o_rv_word  <= 1'b0;
            o_rv_ds    <= 2'b00;
            o_rv_we    <= 1'b0;
        end else begin
            valid_r    <= i_rv_valid;
            o_rv_ready <= 1'b0;
            // remember a request that lands while busy
            if (req_now) begin
                req_pend <= 1'b1;
            end
            case (state)
                RV_IDLE_REQ0: begin
                    if (issue) begin
                        req_pend <= 1'b0;
                        o_rv_req <= ~o_rv_req;
                        o_rv_we  <= is_write;
                        if (is_write && i_rv_wstrb[1:0] == 2'b00) begin
                            // upper half only, lower access skipped
                            o_rv_word <= 1'b1;
                            o_rv_ds   <= i_rv_wstrb[3:2];
                            state     <= RV_WAIT1;
                        end else begin
                            o_rv_word <= 1'b0;
                            o_rv_ds   <= is_write ? i_rv_wstrb[1:0] : 2'b11;
                            state     <= RV_WAIT0_REQ1;
                        end
                    end
                end
                RV_WAIT0_REQ1: begin
                    if (acked) begin
                        o_rv_word <= 1'b1;
                        if (is_write && i_rv_wstrb[3:2] == 2'b00) begin
                            // lower half only, done now
                            o_rv_ready <= 1'b1;
                            state      <= RV_IDLE_REQ0;
                        end else if (is_write) begin
                            o_rv_req <= ~o_rv_req;
                            o_rv_ds  <= i_rv_wstrb[3:2];
                            state    <= RV_WAIT1;
                        end else begin
                            // read, upper issued while lower is captured
                            o_rv_req <= ~o_rv_req;
                            o_rv_ds  <= 2'b11;
                            state    <= RV_DATA0;
                        end
                    end
                end
                RV_DATA0: begin
                    state <= RV_WAIT1;
                end
                RV_WAIT1: begin
                    if (acked) begin
                        if (o_rv_we) begin
                            o_rv_ready <= 1'b1;
                            state      <= RV_IDLE_REQ0;
                        end else begin
                            state <= RV_DATA1;
                        end
                    end
                end
                RV_DATA1: begin
                    o_rv_ready <= 1'b1;
                    state      <= RV_IDLE_REQ0;
                end
                default: begin
                    state <= RV_IDLE_REQ0;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // address and read data

    always_ff @(posedge clk) begin
        if (issue) begin
            o_rv_addr <= i_rv_addr;
        end
        // lower half one cycle after its ack
        if (state == RV_DATA0) begin
            rdata_lo <= i_rv_dout;
        end
        // whole word changes only when a read finishes
        if (state == RV_DATA1) begin
            o_rv_rdata <= {i_rv_dout, rdata_lo};
        end
    end

    a_ready_single: assert property (
        @(posedge clk) disable iff (!sys_resetn)
        o_rv_ready |=> !o_rv_ready
    );

    // no second request before the memory has answered
    a_req_outstanding: assert property (
        @(posedge clk) disable iff (!sys_resetn)
        (o_rv_req != i_rv_req_ack) |=> $stable(o_rv_req)
    );

endmodule

// ==== design/rom_load_sequencer.sv ====
/*
 * ROM load sequencer
 * frames a ROM load, stretches loader writes onto the console memory port,
 * latches the mapper flags and drives console reset and the memory phase
 */
`timescale 1ns/10ps
`include "nes_glue_config.svh"

module rom_load_sequencer (
    input  logic                       clk,
    input  logic                       sys_resetn,
    input  logic                       i_loading,
    input  logic                       i_loader_write,
    input  nes_mem_pkg::mem_addr_t     i_loader_addr,
    input  nes_mem_pkg::mem_byte_t     i_loader_data,
    input  logic                       i_loader_done,
    input  nes_mem_pkg::mapper_flags_t i_loader_flags,
    input  nes_mem_pkg::mem_addr_t     i_cpu_addr,
    input  logic                       i_cpu_read,
    input  logic                       i_cpu_write,
    input  nes_mem_pkg::mem_byte_t     i_cpu_dout,
    output nes_mem_pkg::mem_addr_t     o_mem_addr,
    output nes_mem_pkg::mem_byte_t     o_mem_din,
    output logic                       o_mem_we,
    output logic                       o_mem_oe,
    output logic                       o_loader_reset,
    output logic                       o_reset_nes,
    output logic                       o_clkref,
    output nes_mem_pkg::mapper_flags_t o_mapper_flags,
    output logic                       o_ext_audio
);
    import nes_mem_pkg::*;

    logic      loading_r;
    logic      load_start;
    logic      load_end;
    logic      write_r;
    logic      write_mem;
    mem_addr_t loader_addr_mem;
    mem_byte_t loader_data_mem;
    mem_byte_t mapper_num;

    assign load_start = i_loading & ~loading_r;
    assign load_end   = ~i_loading & loading_r;

    // mapper number straight from the incoming flags
    assign mapper_num = i_loader_flags[7:0];

    ////////////////////////////////////////////////////////////////////////////
    // load framing

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_r      <= 1'b0;
            o_loader_reset <= 1'b0;
            o_reset_nes    <= 1'b1;
            o_clkref       <= 1'b0;
        end else begin
            loading_r      <= i_loading;
            // loader restarts with every new image
            o_loader_reset <= load_start;
            // free running phase reference
            o_clkref       <= ~o_clkref;
            if (load_end) begin
                // console leaves reset, phase realigned
                o_reset_nes <= 1'b0;
                o_clkref    <= 1'b1;
            end else if (load_start) begin
                o_reset_nes <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // loader write stretch

    // one-cycle strobe becomes two cycles of we
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            write_r   <= 1'b0;
            write_mem <= 1'b0;
        end else begin
            write_r   <= i_loader_write;
            write_mem <= i_loader_write | write_r;
        end
    end

    // address and byte held for both cycles
    always_ff @(posedge clk) begin
        if (i_loader_write) begin
            loader_addr_mem <= i_loader_addr;
            loader_data_mem <= i_loader_data;
        end
    end

    // loader owns the port for the whole load
    assign o_mem_addr = i_loading ? loader_addr_mem : i_cpu_addr;
    assign o_mem_din  = i_loading ? loader_data_mem : i_cpu_dout;
    assign o_mem_oe   = ~i_loading & i_cpu_read;
    assign o_mem_we   = write_mem | i_cpu_write;

    ////////////////////////////////////////////////////////////////////////////
    // mapper flags

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            o_mapper_flags <= '0;
            o_ext_audio    <= 1'b0;
        end else if (i_loader_done) begin
            o_mapper_flags <= i_loader_flags;
            // VRC6 and N163 boards mix their own channels
            o_ext_audio    <= (mapper_num == mem_byte_t'(`MAPPER_VRC6_A)) ||
                              (mapper_num == mem_byte_t'(`MAPPER_VRC6_B)) ||
                              (mapper_num == mem_byte_t'(`MAPPER_N163));
        end
    end

    // loader reset is a single pulse per load
    a_loader_reset_pulse: assert property (
        @(posedge clk) disable iff (!sys_resetn)
        o_loader_reset |=> !o_loader_reset
    );

endmodule

// ==== design/nes_pad_pkg.sv ====
/*
 * NES joypad types
 * button word and per-port serial lines
 */
`include "nes_glue_config.svh"

package nes_pad_pkg;

    // bit 0 A, 1 B, 2 Select, 3 Start
    // bit 4 Up, 5 Down, 6 Left, 7 Right
    typedef logic [`PAD_BITS-1:0] pad_buttons_t;

    // one serial clock per port, driven by the console
    typedef logic [`PAD_PORTS-1:0] pad_clock_t;

    // serial data back to the console
    typedef logic [`PAD_PORTS-1:0] pad_data_t;

endpackage

// ==== design/nes_mem_pkg.sv ====
/*
 * NES memory types
 * console memory port, ROM loader and soft-core bus payloads
 */
`include "nes_glue_config.svh"

package nes_mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // console side

    // byte address into SDRAM
    typedef logic [`NES_MEM_ADDR_W-1:0] mem_addr_t;

    typedef logic [7:0] mem_byte_t;

    // header flags from the loader
    // bits 7:0 hold the mapper number
    typedef logic [`MAPPER_FLAGS_W-1:0] mapper_flags_t;

    ////////////////////////////////////////////////////////////////////////////
    // soft-core side

    typedef logic [`RV_ADDR_W-1:0] rv_addr_t;

    // one core word
    typedef logic [31:0] rv_word_t;

    // one memory access
    typedef logic [15:0] rv_half_t;

    // write strobe per byte of the word
    typedef logic [3:0] rv_strb_t;

    // byte enables for one half-word access
    typedef logic [1:0] rv_ds_t;

endpackage

// ==== design/nes_glue_config.svh ====
/*
 * NES glue configuration
 * bus widths, joypad geometry and the mapper numbers that carry external audio
 */
`ifndef NES_GLUE_CONFIG_SVH
`define NES_GLUE_CONFIG_SVH

// console memory address, 4M bytes
`define NES_MEM_ADDR_W 22

// soft-core byte address
`define RV_ADDR_W 23

// loader flag word, low byte is the mapper
`define MAPPER_FLAGS_W 64

// joypad geometry
`define PAD_BITS 8
`define PAD_PORTS 2

// mappers with an expansion audio chip
`define MAPPER_VRC6_A 24
`define MAPPER_VRC6_B 26
`define MAPPER_N163 19

`endif
